/* amo_alu.sv */
// Registered read-modify-write arithmetic for AMOs, result valid one cycle after inputs
`default_nettype none

module amo_alu (
    input  logic               clk,
    input  logic               rstn,
    input  lsu_pkg::word_t     original,
    input  lsu_pkg::word_t     operand,
    input  lsu_pkg::amo_op_t   amo,
    input  lsu_pkg::mem_size_t size,
    output lsu_pkg::word_t     result
);

    lsu_pkg::word_t op_b;
    lsu_pkg::word_t next_result;
    logic           lt_s;
    logic           lt_u;

    // Word atomics compare on sign-extended 32-bit values
    assign op_b = (size == lsu_pkg::size_word) ?
                  {{(lsu_pkg::xlen-32){operand[31]}}, operand[31:0]} : operand;

    assign lt_s = $signed(original) < $signed(op_b);
    assign lt_u = original < op_b;

    always_comb begin
        case (amo)
            lsu_pkg::amo_swap: next_result = op_b;
            lsu_pkg::amo_add:  next_result = original + op_b;
            lsu_pkg::amo_xor:  next_result = original ^ op_b;
            lsu_pkg::amo_and:  next_result = original & op_b;
            lsu_pkg::amo_or:   next_result = original | op_b;
            lsu_pkg::amo_min:  next_result = lt_s ? original : op_b;
            lsu_pkg::amo_max:  next_result = lt_s ? op_b : original;
            lsu_pkg::amo_minu: next_result = lt_u ? original : op_b;
            lsu_pkg::amo_maxu: next_result = lt_u ? op_b : original;
            default:           next_result = op_b;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            result <= '0;
        end else begin
            result <= next_result;
        end
    end

endmodule

`default_nettype wire

/* axi_pkg.sv */
// Bus-side widths and types of the reduced AXI port; referenced by scoped name
`default_nettype none

package axi_pkg;

    localparam int addr_w = 64;
    localparam int data_w = 64;
    localparam int strb_w = data_w / 8;

    // Byte lane select within one beat
    localparam int offset_w = $clog2(strb_w);

    typedef logic [addr_w-1:0]   addr_t;
    typedef logic [data_w-1:0]   data_t;
    typedef logic [strb_w-1:0]   strb_t;
    typedef logic [offset_w-1:0] offset_t;

endpackage

`default_nettype wire

/* data_aligner.sv */
// Alignment check, load lane extraction and store lane placement between CPU and bus
`default_nettype none

module data_aligner (
    input  axi_pkg::offset_t   offset,
    input  lsu_pkg::mem_size_t size,
    input  logic               is_unsigned,
    input  axi_pkg::data_t     r_data,
    input  lsu_pkg::word_t     store_value,
    output logic               misaligned,
    output lsu_pkg::word_t     load_value,
    output axi_pkg::data_t     w_data,
    output axi_pkg::strb_t     w_strb
);

    logic [5:0]     shamt;
    axi_pkg::data_t shifted;
    logic           sx;

    assign shamt   = {offset, 3'b000};
    assign shifted = r_data >> shamt;   // Addressed lanes moved to bit 0
    assign sx      = ~is_unsigned;

    assign w_data = store_value << shamt;

    always_comb begin
        misaligned = 1'b0;
        load_value = shifted;
        w_strb     = '1;
        unique case (size)
            lsu_pkg::size_byte: begin
                load_value = {{(lsu_pkg::xlen-8){sx & shifted[7]}}, shifted[7:0]};
                w_strb     = axi_pkg::strb_t'(8'h01) << offset;
            end
            lsu_pkg::size_half: begin
                misaligned = offset[0];
                load_value = {{(lsu_pkg::xlen-16){sx & shifted[15]}}, shifted[15:0]};
                w_strb     = axi_pkg::strb_t'(8'h03) << offset;
            end
            lsu_pkg::size_word: begin
                misaligned = |offset[1:0];
                load_value = {{(lsu_pkg::xlen-32){sx & shifted[31]}}, shifted[31:0]};
                w_strb     = axi_pkg::strb_t'(8'h0f) << offset;
            end
            lsu_pkg::size_double: begin
                misaligned = |offset;
                load_value = shifted;  // Full beat, nothing to extend
                w_strb     = '1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* dcache_asserts.sv */
// Handshake assertions for the uncached port; bound into dcache_uncached by the testbench
`default_nettype none

module dcache_asserts (
    input logic           clk,
    input logic           rstn,
    input logic           req_ready,
    input logic           ar_valid,
    input logic           ar_ready,
    input axi_pkg::addr_t ar_addr,
    input logic           aw_valid,
    input logic           aw_ready,
    input axi_pkg::addr_t aw_addr,
    input logic           w_valid,
    input logic           w_ready,
    input axi_pkg::data_t w_data,
    input axi_pkg::strb_t w_strb
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    ar_hold: assert property (@(posedge clk) disable iff (!rstn)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr))
        else begin
            failures++;
            $error("AR valid or address changed before ar_ready");
        end

    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr))
        else begin
            failures++;
            $error("AW valid or address changed before aw_ready");
        end

    w_hold: assert property (@(posedge clk) disable iff (!rstn)
        w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_strb))
        else begin
            failures++;
            $error("W valid, data or strobe changed before w_ready");
        end

    // CPU side only ready while the bus is quiet
    ready_idle: assert property (@(posedge clk) disable iff (!rstn)
        !(req_ready && (ar_valid || aw_valid || w_valid)))
        else begin
            failures++;
            $error("req_ready high while a bus valid is high");
        end

    reset_quiet: assert property (@(posedge clk)
        !rstn |-> !ar_valid && !aw_valid && !w_valid)
        else begin
            failures++;
            $error("Bus valid high during reset");
        end

endmodule

`default_nettype wire

/* dcache_uncached.sv */
// Top level of the uncached data port; instantiate between the CPU and the AXI memory bus
`default_nettype none

module dcache_uncached (
    input  logic                clk,
    input  logic                rstn,
    // CPU request
    input  logic                req_valid,
    output logic                req_ready,
    input  lsu_pkg::mem_op_t    req_op,
    input  lsu_pkg::mem_size_t  req_size,
    input  logic                req_unsigned,
    input  lsu_pkg::amo_op_t    req_amo,
    input  axi_pkg::addr_t      req_address,
    input  lsu_pkg::word_t      req_value,
    // CPU response
    output logic                resp_valid,
    output lsu_pkg::word_t      resp_value,
    output logic                resp_exc_valid,
    output lsu_pkg::exc_cause_t resp_exc_cause,
    output axi_pkg::addr_t      resp_exc_tval,
    // AXI, R and B always accepted
    output logic                ar_valid,
    input  logic                ar_ready,
    output axi_pkg::addr_t      ar_addr,
    input  logic                r_valid,
    input  axi_pkg::data_t      r_data,
    output logic                aw_valid,
    input  logic                aw_ready,
    output axi_pkg::addr_t      aw_addr,
    output logic                w_valid,
    input  logic                w_ready,
    output axi_pkg::data_t      w_data,
    output axi_pkg::strb_t      w_strb,
    input  logic                b_valid
);

    axi_pkg::offset_t   offset;
    lsu_pkg::mem_size_t size;
    logic               is_unsigned;
    lsu_pkg::word_t     store_value;
    logic               misaligned;
    lsu_pkg::word_t     load_value;
    lsu_pkg::word_t     amo_original;
    lsu_pkg::word_t     amo_operand;
    lsu_pkg::amo_op_t   amo_code;
    lsu_pkg::word_t     amo_result;
    axi_pkg::addr_t     bus_addr;

    assign ar_addr = bus_addr;
    assign aw_addr = bus_addr;  // Only one beat ever outstanding

    lsu_fsm i_fsm (
        .clk            (clk),
        .rstn           (rstn),
        .req_valid      (req_valid),
        .req_ready      (req_ready),
        .req_op         (req_op),
        .req_size       (req_size),
        .req_unsigned   (req_unsigned),
        .req_amo        (req_amo),
        .req_address    (req_address),
        .req_value      (req_value),
        .offset         (offset),
        .size           (size),
        .is_unsigned    (is_unsigned),
        .store_value    (store_value),
        .misaligned     (misaligned),
        .load_value     (load_value),
        .amo_original   (amo_original),
        .amo_operand    (amo_operand),
        .amo_code       (amo_code),
        .amo_result     (amo_result),
        .ar_valid       (ar_valid),
        .ar_ready       (ar_ready),
        .r_valid        (r_valid),
        .aw_valid       (aw_valid),
        .aw_ready       (aw_ready),
        .w_valid        (w_valid),
        .w_ready        (w_ready),
        .b_valid        (b_valid),
        .bus_addr       (bus_addr),
        .resp_valid     (resp_valid),
        .resp_value     (resp_value),
        .resp_exc_valid (resp_exc_valid),
        .resp_exc_cause (resp_exc_cause),
        .resp_exc_tval  (resp_exc_tval)
    );

    data_aligner i_aligner (
        .offset      (offset),
        .size        (size),
        .is_unsigned (is_unsigned),
        .r_data      (r_data),
        .store_value (store_value),
        .misaligned  (misaligned),
        .load_value  (load_value),
        .w_data      (w_data),
        .w_strb      (w_strb)
    );

    amo_alu i_amo (
        .clk      (clk),
        .rstn     (rstn),
        .original (amo_original),
        .operand  (amo_operand),
        .amo      (amo_code),
        .size     (size),
        .result   (amo_result)
    );

endmodule

`default_nettype wire

/* lsu_fsm.sv */
// Request latch and bus sequencer of the uncached port; drives the aligner and AMO unit
`default_nettype none

module lsu_fsm (
    input  logic                   clk,
    input  logic                   rstn,
    // CPU request
    input  logic                   req_valid,
    output logic                   req_ready,
    input  lsu_pkg::mem_op_t       req_op,
    input  lsu_pkg::mem_size_t     req_size,
    input  logic                   req_unsigned,
    input  lsu_pkg::amo_op_t       req_amo,
    input  axi_pkg::addr_t         req_address,
    input  lsu_pkg::word_t         req_value,
    // Aligner
    output axi_pkg::offset_t       offset,
    output lsu_pkg::mem_size_t     size,
    output logic                   is_unsigned,
    output lsu_pkg::word_t         store_value,
    input  logic                   misaligned,
    input  lsu_pkg::word_t         load_value,
    // AMO unit
    output lsu_pkg::word_t         amo_original,
    output lsu_pkg::word_t         amo_operand,
    output lsu_pkg::amo_op_t       amo_code,
    input  lsu_pkg::word_t         amo_result,
    // Bus
    output logic                   ar_valid,
    input  logic                   ar_ready,
    input  logic                   r_valid,
    output logic                   aw_valid,
    input  logic                   aw_ready,
    output logic                   w_valid,
    input  logic                   w_ready,
    input  logic                   b_valid,
    output axi_pkg::addr_t         bus_addr,
    // CPU response
    output logic                   resp_valid,
    output lsu_pkg::word_t         resp_value,
    output logic                   resp_exc_valid,
    output lsu_pkg::exc_cause_t    resp_exc_cause,
    output axi_pkg::addr_t         resp_exc_tval
);

    typedef enum logic [1:0] {
        state_idle,
        state_wait_r,   // AR issued, waiting for R
        state_amo,
        state_wait_w    // AW and W issued, waiting for B
    } state_t;

    state_t             state;
    axi_pkg::addr_t     addr_q;
    lsu_pkg::mem_op_t   op_q;
    lsu_pkg::mem_size_t size_q;
    logic               unsigned_q;
    lsu_pkg::word_t     value_q;
    lsu_pkg::amo_op_t   amo_q;
    logic               accept;

    assign req_ready = (state == state_idle);
    assign accept    = req_valid && req_ready;

    // Live request while idle so the alignment check needs no extra cycle
    assign offset = req_ready ? req_address[axi_pkg::offset_w-1:0]
                              : addr_q[axi_pkg::offset_w-1:0];
    assign size   = req_ready ? req_size : size_q;

    assign is_unsigned  = unsigned_q;
    assign store_value  = (op_q == lsu_pkg::mem_amo) ? amo_result : value_q;
    assign amo_original = resp_value;   // Old memory value from the read
    assign amo_operand  = value_q;
    assign amo_code     = amo_q;
    assign bus_addr     = addr_q;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state          <= state_idle;
            ar_valid       <= 1'b0;
            aw_valid       <= 1'b0;
            w_valid        <= 1'b0;
            resp_valid     <= 1'b0;
            resp_exc_valid <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            unique case (state)
                state_idle: begin
                    if (accept) begin
                        resp_exc_valid <= misaligned;
                        if (misaligned) begin
                            resp_valid <= 1'b1;   // No bus access at all
                        end else if (req_op == lsu_pkg::mem_store) begin
                            aw_valid <= 1'b1;
                            w_valid  <= 1'b1;
                            state    <= state_wait_w;
                        end else begin
                            ar_valid <= 1'b1;
                            state    <= state_wait_r;
                        end
                    end
                end
                state_wait_r: begin
                    if (ar_ready) begin
                        ar_valid <= 1'b0;
                    end
                    if (r_valid) begin
                        if (op_q == lsu_pkg::mem_amo) begin
                            state <= state_amo;
                        end else begin
                            resp_valid <= 1'b1;
                            state      <= state_idle;
                        end
                    end
                end
                state_amo: begin
                    // ALU result registers during this cycle
                    aw_valid <= 1'b1;
                    w_valid  <= 1'b1;
                    state    <= state_wait_w;
                end
                state_wait_w: begin
                    if (aw_ready) begin
                        aw_valid <= 1'b0;
                    end
                    if (w_ready) begin
                        w_valid <= 1'b0;
                    end
                    if (b_valid) begin
                        resp_valid <= 1'b1;
                        state      <= state_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q         <= req_address;
            op_q           <= req_op;
            size_q         <= req_size;
            unsigned_q     <= req_unsigned;
            value_q        <= req_value;
            amo_q          <= req_amo;
            resp_value     <= '0;
            resp_exc_tval  <= req_address;
            resp_exc_cause <= (req_op == lsu_pkg::mem_load) ?
                              lsu_pkg::cause_load_misaligned :
                              lsu_pkg::cause_store_misaligned;
        end
        if (state == state_wait_r && r_valid) begin
            resp_value <= load_value;   // Kept through the write for AMO
        end
    end

endmodule

`default_nettype wire

/* lsu_pkg.sv */
// CPU-side types and constants for the load/store port; referenced by scoped name
`default_nettype none

package lsu_pkg;

    localparam int xlen = 64;

    typedef logic [xlen-1:0] word_t;

    typedef enum logic [1:0] {
        mem_load,
        mem_store,
        mem_amo
    } mem_op_t;

    // Access size, log2 of the byte count
    typedef logic [1:0] mem_size_t;

    localparam mem_size_t size_byte   = 2'd0;
    localparam mem_size_t size_half   = 2'd1;
    localparam mem_size_t size_word   = 2'd2;
    localparam mem_size_t size_double = 2'd3;

    // funct5 field of the AMO instruction
    typedef enum logic [4:0] {
        amo_add  = 5'b00000,
        amo_swap = 5'b00001,
        amo_xor  = 5'b00100,
        amo_or   = 5'b01000,
        amo_and  = 5'b01100,
        amo_min  = 5'b10000,
        amo_max  = 5'b10100,
        amo_minu = 5'b11000,
        amo_maxu = 5'b11100
    } amo_op_t;

    typedef logic [3:0] exc_cause_t;

    localparam exc_cause_t cause_load_misaligned  = 4'd4;
    localparam exc_cause_t cause_store_misaligned = 4'd6; // Also used for AMO

endpackage

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status reflects the result
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_dcache_uncached -f sources.f -o sim
./obj_dir/sim | tee sim.log

if grep -q "all tests passed" sim.log; then
    echo "Simulation PASS"
else
    echo "Simulation FAIL"
    exit 1
fi

/* sources.f */
lsu_pkg.sv
axi_pkg.sv
data_aligner.sv
amo_alu.sv
lsu_fsm.sv
dcache_uncached.sv
dcache_asserts.sv
tb_dcache_uncached.sv

/* tb_dcache_uncached.sv */
// Directed testbench for the uncached data port with an AXI memory model; run as the sim top
`default_nettype none

module tb_dcache_uncached;
    timeunit 1ns;
    timeprecision 1ps;

    // 127 transactions, each well under 30 cycles even with back-pressure
    localparam int max_cycles = 4000;
    localparam axi_pkg::addr_t mem_base = 64'h0000_0000_8000_0000;

    logic                clk = 1'b0;
    logic                rstn;
    logic                req_valid;
    logic                req_ready;
    lsu_pkg::mem_op_t    req_op;
    lsu_pkg::mem_size_t  req_size;
    logic                req_unsigned;
    lsu_pkg::amo_op_t    req_amo;
    axi_pkg::addr_t      req_address;
    lsu_pkg::word_t      req_value;
    logic                resp_valid;
    lsu_pkg::word_t      resp_value;
    logic                resp_exc_valid;
    lsu_pkg::exc_cause_t resp_exc_cause;
    axi_pkg::addr_t      resp_exc_tval;
    logic                ar_valid;
    logic                ar_ready;
    axi_pkg::addr_t      ar_addr;
    logic                r_valid;
    axi_pkg::data_t      r_data;
    logic                aw_valid;
    logic                aw_ready;
    axi_pkg::addr_t      aw_addr;
    logic                w_valid;
    logic                w_ready;
    axi_pkg::data_t      w_data;
    axi_pkg::strb_t      w_strb;
    logic                b_valid;

    logic [63:0]    mem [64];
    logic           backpressure = 1'b0;
    logic           rd_busy = 1'b0;
    logic           aw_done = 1'b0;
    logic           w_done = 1'b0;
    axi_pkg::addr_t rd_addr;
    axi_pkg::addr_t cur_addr = '0;
    int             cycles = 0;
    int             last_wait;

    dcache_uncached i_dut (.*);

    bind dcache_uncached dcache_asserts i_asserts (
        .clk       (clk),
        .rstn      (rstn),
        .req_ready (req_ready),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar_addr   (ar_addr),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .aw_addr   (aw_addr),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .w_data    (w_data),
        .w_strb    (w_strb)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("tests failed");
            $fatal(1, "timeout");
        end else if (i_dut.i_asserts.failures != 0) begin
            $display("A bound handshake assertion failed");
            $display("tests failed");
            $fatal(1, "assertion");
        end
    end

    // Memory model, one beat at a time
    always @(posedge clk) begin
        r_valid  <= 1'b0;
        b_valid  <= 1'b0;
        ar_ready <= !backpressure || ($urandom_range(0, 1) == 1);
        aw_ready <= !backpressure || ($urandom_range(0, 1) == 1);
        w_ready  <= !backpressure || ($urandom_range(0, 1) == 1);
        if (ar_valid && ar_ready) begin
            check("ar_addr", ar_addr >> 3, cur_addr >> 3);  // Doubleword of the beat
            rd_addr = ar_addr;
            rd_busy = 1'b1;
        end else if (rd_busy && $urandom_range(0, 2) == 0) begin
            r_valid <= 1'b1;
            r_data  <= mem[rd_addr[8:3]];
            rd_busy = 1'b0;
        end
        if (aw_valid && aw_ready) begin
            check("aw_addr", aw_addr >> 3, cur_addr >> 3);
            aw_done = 1'b1;
        end
        if (w_valid && w_ready) begin
            w_done = 1'b1;
            for (int i = 0; i < 8; i++) begin
                if (w_strb[i]) begin
                    mem[aw_addr[8:3]][i*8 +: 8] = w_data[i*8 +: 8];
                end
            end
        end
        if (aw_done && w_done && $urandom_range(0, 2) == 0) begin
            b_valid <= 1'b1;
            aw_done = 1'b0;
            w_done  = 1'b0;
        end
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("tests failed");
            $fatal(1, "value check");
        end
    endtask

    function automatic axi_pkg::addr_t addr_of(input int idx, input int off);
        return mem_base + axi_pkg::addr_t'(idx * 8 + off);
    endfunction

    // Bytes at off, extended to 64 bits
    function automatic logic [63:0] expect_load(input logic [63:0] dw, input int off,
                                                input int nbytes, input logic uns);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < nbytes; i++) begin
            v[i*8 +: 8] = dw[(off + i)*8 +: 8];
        end
        if (!uns && v[nbytes*8 - 1]) begin
            for (int i = nbytes; i < 8; i++) begin
                v[i*8 +: 8] = 8'hff;
            end
        end
        return v;
    endfunction

    function automatic logic [63:0] merge_store(input logic [63:0] old, input logic [63:0] value,
                                                input int off, input int nbytes);
        logic [63:0] v;
        v = old;
        for (int i = 0; i < nbytes; i++) begin
            v[(off + i)*8 +: 8] = value[i*8 +: 8];
        end
        return v;
    endfunction

    task automatic amo_reference(input lsu_pkg::amo_op_t code, input logic [63:0] a,
                                 input logic [63:0] b_in, input int nbytes,
                                 output logic [63:0] r);
        logic [63:0] b;
        b = (nbytes == 4) ? {{32{b_in[31]}}, b_in[31:0]} : b_in;
        case (code)
            lsu_pkg::amo_swap: r = b;
            lsu_pkg::amo_add:  r = a + b;
            lsu_pkg::amo_xor:  r = a ^ b;
            lsu_pkg::amo_and:  r = a & b;
            lsu_pkg::amo_or:   r = a | b;
            lsu_pkg::amo_min:  r = ($signed(a) < $signed(b)) ? a : b;
            lsu_pkg::amo_max:  r = ($signed(a) > $signed(b)) ? a : b;
            lsu_pkg::amo_minu: r = (a < b) ? a : b;
            default:           r = (a > b) ? a : b;   // maxu
        endcase
    endtask

    // One request through to its response; req_ready must stay low in between
    task automatic transact(input lsu_pkg::mem_op_t op, input int s, input logic uns,
                            input lsu_pkg::amo_op_t code, input axi_pkg::addr_t addr,
                            input lsu_pkg::word_t value);
        cur_addr = addr;
        @(posedge clk);
        req_valid    <= 1'b1;
        req_op       <= op;
        req_size     <= lsu_pkg::mem_size_t'(s);
        req_unsigned <= uns;
        req_amo      <= code;
        req_address  <= addr;
        req_value    <= value;
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);   // Accepted here
        req_valid <= 1'b0;
        last_wait = 0;
        @(negedge clk);
        while (!resp_valid) begin
            check("req_ready", 64'(req_ready), 64'd0);
            last_wait++;
            @(negedge clk);
        end
    endtask

    task automatic test_loads();
        int idx;
        for (int s = 0; s < 4; s++) begin
            for (int off = 0; off < 8; off += 1 << s) begin
                for (int u = 0; u < 2; u++) begin
                    idx = $urandom_range(0, 63);
                    transact(lsu_pkg::mem_load, s, 1'(u), lsu_pkg::amo_add, addr_of(idx, off), '0);
                    check("resp_exc_valid", 64'(resp_exc_valid), 64'd0);
                    check("resp_value", resp_value, expect_load(mem[idx], off, 1 << s, u != 0));
                end
            end
        end
    endtask

    task automatic test_stores();
        int             idx;
        lsu_pkg::word_t value;
        logic [63:0]    exp;
        for (int s = 0; s < 4; s++) begin
            for (int off = 0; off < 8; off += 1 << s) begin
                idx   = $urandom_range(0, 63);
                value = {$urandom, $urandom};
                exp   = merge_store(mem[idx], value, off, 1 << s);
                transact(lsu_pkg::mem_store, s, 1'b0, lsu_pkg::amo_add, addr_of(idx, off), value);
                check("resp_exc_valid", 64'(resp_exc_valid), 64'd0);
                check("resp_value", resp_value, 64'd0);
                transact(lsu_pkg::mem_load, 3, 1'b0, lsu_pkg::amo_add, addr_of(idx, 0), '0);
                check("resp_value", resp_value, exp);
            end
        end
    endtask

    task automatic test_misaligned();
        axi_pkg::addr_t addr;
        for (int s = 1; s < 4; s++) begin
            for (int k = 0; k < 3; k++) begin
                addr = addr_of($urandom_range(0, 63), (1 << s) - 1);
                transact(lsu_pkg::mem_op_t'(k), s, 1'b0, lsu_pkg::amo_swap, addr,
                         64'h5a5a_0000_ffff_1234);
                check("resp_exc_valid", 64'(resp_exc_valid), 64'd1);
                check("resp_exc_cause", 64'(resp_exc_cause), (k == 0) ? 64'd4 : 64'd6);
                check("resp_exc_tval", resp_exc_tval, addr);
                check("resp_valid delay", 64'(last_wait), 64'd0);
                check("req_ready", 64'(req_ready), 64'd1);
                // A bus access would already show its valid here
                check("ar_valid", 64'(ar_valid), 64'd0);
                check("aw_valid", 64'(aw_valid), 64'd0);
                check("w_valid", 64'(w_valid), 64'd0);
            end
        end
    endtask

    task automatic test_amos();
        lsu_pkg::amo_op_t codes [9];
        int               s;
        int               off;
        int               idx;
        lsu_pkg::word_t   operand;
        logic [63:0]      old;
        logic [63:0]      result;
        logic [63:0]      exp;
        codes = '{lsu_pkg::amo_swap, lsu_pkg::amo_add, lsu_pkg::amo_xor, lsu_pkg::amo_and,
                  lsu_pkg::amo_or, lsu_pkg::amo_min, lsu_pkg::amo_max, lsu_pkg::amo_minu,
                  lsu_pkg::amo_maxu};
        for (int c = 0; c < 9; c++) begin
            for (int w = 0; w < 2; w++) begin
                s       = (w == 0) ? 2 : 3;
                off     = (s == 2) ? 4 * $urandom_range(0, 1) : 0;
                idx     = $urandom_range(0, 63);
                operand = {$urandom, $urandom};
                old     = expect_load(mem[idx], off, 1 << s, 1'b0);
                amo_reference(codes[c], old, operand, 1 << s, result);
                exp = merge_store(mem[idx], result, off, 1 << s);
                transact(lsu_pkg::mem_amo, s, 1'b0, codes[c], addr_of(idx, off), operand);
                check("resp_exc_valid", 64'(resp_exc_valid), 64'd0);
                check("resp_value", resp_value, old);
                check("mem after amo", mem[idx], exp);
            end
        end
    endtask

    task automatic test_backpressure();
        int             s;
        int             off;
        int             idx;
        lsu_pkg::word_t value;
        logic [63:0]    exp;
        backpressure = 1'b1;
        for (int n = 0; n < 40; n++) begin
            s     = $urandom_range(0, 3);
            off   = $urandom_range(0, 7) & ~((1 << s) - 1);
            idx   = $urandom_range(0, 63);
            value = {$urandom, $urandom};
            if ($urandom_range(0, 1) == 1) begin
                exp = merge_store(mem[idx], value, off, 1 << s);
                transact(lsu_pkg::mem_store, s, 1'b0, lsu_pkg::amo_add, addr_of(idx, off), value);
                check("resp_value", resp_value, 64'd0);
                check("mem after store", mem[idx], exp);
            end else begin
                exp = expect_load(mem[idx], off, 1 << s, 1'b0);
                transact(lsu_pkg::mem_load, s, 1'b0, lsu_pkg::amo_add, addr_of(idx, off), '0);
                check("resp_value", resp_value, exp);
            end
        end
        backpressure = 1'b0;
    endtask

    initial begin
        void'($urandom(16134));
        rstn         = 1'b0;
        req_valid    = 1'b0;
        req_op       = lsu_pkg::mem_load;
        req_size     = lsu_pkg::size_byte;
        req_unsigned = 1'b0;
        req_amo      = lsu_pkg::amo_add;
        req_address  = '0;
        req_value    = '0;
        ar_ready     = 1'b0;
        r_valid      = 1'b0;
        r_data       = '0;
        aw_ready     = 1'b0;
        w_ready      = 1'b0;
        b_valid      = 1'b0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = 64'(i + 1) * 64'h9e37_79b9_7f4a_7c15;  // Every index bit matters
        end
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check("req_ready", 64'(req_ready), 64'd1);
        check("resp_valid", 64'(resp_valid), 64'd0);
        check("ar_valid", 64'(ar_valid), 64'd0);
        check("aw_valid", 64'(aw_valid), 64'd0);
        check("w_valid", 64'(w_valid), 64'd0);
        test_loads();
        test_stores();
        test_misaligned();
        test_amos();
        test_backpressure();
        if (i_dut.i_asserts.failures == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("%0d assertion failures", i_dut.i_asserts.failures);
            $display("tests failed");
            $fatal(1, "assertions");
        end
    end

endmodule

`default_nettype wire
